// ==== logic/rvAlu.sv ====
module rvAlu (
    input  logic [rvCorePkg::xlen-1:0]    opA,
    input  logic [rvCorePkg::xlen-1:0]    opB,
    input  rvCorePkg::aluOp_e             aluOp,
    output logic [rvCorePkg::xlen-1:0]    result
);

    logic [5:0]  shamt;
    logic [31:0] wordRes;

    // word ops only see 5 shift bits
    assign shamt = aluOp[4] ? {1'b0, opB[4:0]} : opB[5:0];

    always_comb begin
        wordRes = '0;
        case (aluOp)
            rvCorePkg::aluAdd:   result = opA + opB;
            rvCorePkg::aluSub:   result = opA - opB;
            rvCorePkg::aluSll:   result = opA << shamt;
            rvCorePkg::aluSlt:   result = {63'd0, $signed(opA) < $signed(opB)};
            rvCorePkg::aluSltu:  result = {63'd0, opA < opB};
            rvCorePkg::aluXor:   result = opA ^ opB;
            rvCorePkg::aluSrl:   result = opA >> shamt;
            rvCorePkg::aluSra:   result = $signed(opA) >>> shamt;
            rvCorePkg::aluOr:    result = opA | opB;
            rvCorePkg::aluAnd:   result = opA & opB;
            rvCorePkg::aluPassB: result = opB;
            default:             result = opA + opB;
        endcase
        if (aluOp[4]) begin
            case (aluOp)
                rvCorePkg::aluSubW: wordRes = opA[31:0] - opB[31:0];
                rvCorePkg::aluSllW: wordRes = opA[31:0] << shamt[4:0];
                rvCorePkg::aluSrlW: wordRes = opA[31:0] >> shamt[4:0];
                rvCorePkg::aluSraW: wordRes = $signed(opA[31:0]) >>> shamt[4:0];
                default:            wordRes = opA[31:0] + opB[31:0]; // addw, addiw
            endcase
            result = {{32{wordRes[31]}}, wordRes};
        end
    end

endmodule

// ==== logic/rvCore.sv ====
module rvCore (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [31:0]                   instr,
    input  logic                          instrValid,
    input  logic [rvCorePkg::xlen-1:0]    memRdData,
    output logic [rvCorePkg::xlen-1:0]    pc,
    output logic [rvCorePkg::xlen-1:0]    memAddr,
    output logic [rvCorePkg::xlen-1:0]    memWrData,
    output logic                          memWr,
    output logic                          memRd,
    output logic [2:0]                    memOp,
    output logic                          trap,
    output logic                          halted
);

    rvCorePkg::immFmt_e          immFmt;
    rvCorePkg::aluOp_e           aluOp;
    rvCorePkg::aSel_e            aSel;
    rvCorePkg::bSel_e            bSel;
    rvCorePkg::brKind_e          brKind;
    rvCorePkg::wbSel_e           wbSel;
    logic                        brUnsigned;
    logic                        decRegWr;
    logic                        decMemWr;
    logic                        decMemRd;
    logic                        illegal;
    logic                        advance;
    logic [rvCorePkg::xlen-1:0]  imm;
    logic [rvCorePkg::xlen-1:0]  rs1Data;
    logic [rvCorePkg::xlen-1:0]  rs2Data;
    logic [rvCorePkg::xlen-1:0]  opA;
    logic [rvCorePkg::xlen-1:0]  opB;
    logic [rvCorePkg::xlen-1:0]  aluResult;
    logic [rvCorePkg::xlen-1:0]  pcPlus4;
    logic [rvCorePkg::xlen-1:0]  wbData;

    rvDecode rvDecode_inst (
        .instr(instr), .immFmt(immFmt), .aluOp(aluOp), .aSel(aSel), .bSel(bSel),
        .brKind(brKind), .brUnsigned(brUnsigned), .wbSel(wbSel), .regWr(decRegWr),
        .memWr(decMemWr), .memRd(decMemRd), .memOp(memOp), .illegal(illegal)
    );

    rvImmGen rvImmGen_inst (.instr(instr[31:7]), .immFmt(immFmt), .imm(imm));

    rvRegFile rvRegFile_inst (
        .clk(clk), .arstN(arstN), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rdAddr(instr[11:7]), .rdData(wbData), .wrEn(decRegWr && advance),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign opA = (aSel == rvCorePkg::aSelPc) ? pc : rs1Data;

    always_comb begin
        case (bSel)
            rvCorePkg::bSelRs2:  opB = rs2Data;
            rvCorePkg::bSelFour: opB = 64'd4;
            default:             opB = imm;
        endcase
    end

    rvAlu rvAlu_inst (.opA(opA), .opB(opB), .aluOp(aluOp), .result(aluResult));

    rvNextPc rvNextPc_inst (
        .clk(clk), .arstN(arstN), .advance(advance), .brKind(brKind),
        .brUnsigned(brUnsigned), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .pc(pc), .pcPlus4(pcPlus4), .halted(halted)
    );

    always_comb begin
        case (wbSel)
            rvCorePkg::wbLoad:    wbData = memRdData; // extension done by memory
            rvCorePkg::wbPcPlus4: wbData = pcPlus4;
            default:              wbData = aluResult;
        endcase
    end

    assign trap      = instrValid && illegal;
    assign advance   = instrValid && !trap && !halted;
    assign memAddr   = aluResult;
    assign memWrData = rs2Data;
    assign memWr     = decMemWr && advance;
    assign memRd     = decMemRd && advance;

endmodule

// ==== logic/rvCorePkg.sv ====
package rvCorePkg;

    localparam int xlen = 64;
    localparam logic [xlen-1:0] resetPc = 64'h0000_0000_8000_0000;

    // major opcodes, instr[6:2]
    localparam logic [4:0] opLoad   = 5'b00000;
    localparam logic [4:0] opOpImm  = 5'b00100;
    localparam logic [4:0] opAuipc  = 5'b00101;
    localparam logic [4:0] opOpImmW = 5'b00110;
    localparam logic [4:0] opStore  = 5'b01000;
    localparam logic [4:0] opOp     = 5'b01100;
    localparam logic [4:0] opLui    = 5'b01101;
    localparam logic [4:0] opOpW    = 5'b01110;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opJalr   = 5'b11001;
    localparam logic [4:0] opJal    = 5'b11011;
    localparam logic [4:0] opSystem = 5'b11100;

    localparam logic [31:0] ebreakInstr = 32'h0010_0073;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ
    } immFmt_e;

    // {word, alt, funct3}
    typedef enum logic [4:0] {
        aluAdd   = 5'b00000,
        aluSll   = 5'b00001,
        aluSlt   = 5'b00010,
        aluSltu  = 5'b00011,
        aluXor   = 5'b00100,
        aluSrl   = 5'b00101,
        aluOr    = 5'b00110,
        aluAnd   = 5'b00111,
        aluSub   = 5'b01000,
        aluSra   = 5'b01101,
        aluPassB = 5'b01111, // lui
        aluAddW  = 5'b10000,
        aluSllW  = 5'b10001,
        aluSrlW  = 5'b10101,
        aluSubW  = 5'b11000,
        aluSraW  = 5'b11101
    } aluOp_e;

    typedef enum logic {aSelRs1, aSelPc} aSel_e;

    typedef enum logic [1:0] {bSelRs2, bSelImm, bSelFour} bSel_e;

    // unsigned compares ride on a separate flag
    typedef enum logic [2:0] {
        brNone, brJal, brJalr, brEbreak, brEq, brNe, brLt, brGe
    } brKind_e;

    typedef enum logic [1:0] {wbAlu, wbLoad, wbPcPlus4} wbSel_e;

endpackage

// ==== logic/rvDecode.sv ====
module rvDecode (
    input  logic [31:0]         instr,
    output rvCorePkg::immFmt_e  immFmt,
    output rvCorePkg::aluOp_e   aluOp,
    output rvCorePkg::aSel_e    aSel,
    output rvCorePkg::bSel_e    bSel,
    output rvCorePkg::brKind_e  brKind,
    output logic                brUnsigned,
    output rvCorePkg::wbSel_e   wbSel,
    output logic                regWr,
    output logic                memWr,
    output logic                memRd,
    output logic [2:0]          memOp,
    output logic                illegal
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       shiftAlt; // sra/srai select
    logic       regWrRaw;
    logic       memWrRaw;
    logic       memRdRaw;
    logic       bad;

    assign opcode   = instr[6:2];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign shiftAlt = (funct3 == 3'b101) && funct7[5];
    assign memOp    = funct3;

    always_comb begin
        immFmt     = rvCorePkg::immI;
        aluOp      = rvCorePkg::aluAdd;
        aSel       = rvCorePkg::aSelRs1;
        bSel       = rvCorePkg::bSelImm;
        brKind     = rvCorePkg::brNone;
        brUnsigned = 1'b0;
        wbSel      = rvCorePkg::wbAlu;
        regWrRaw   = 1'b0;
        memWrRaw   = 1'b0;
        memRdRaw   = 1'b0;
        bad        = 1'b0;
        case (opcode)
            rvCorePkg::opLui: begin
                immFmt   = rvCorePkg::immU;
                aluOp    = rvCorePkg::aluPassB;
                regWrRaw = 1'b1;
            end
            rvCorePkg::opAuipc: begin
                immFmt   = rvCorePkg::immU;
                aSel     = rvCorePkg::aSelPc;
                regWrRaw = 1'b1;
            end
            rvCorePkg::opJal, rvCorePkg::opJalr: begin
                immFmt   = (opcode == rvCorePkg::opJal) ? rvCorePkg::immJ : rvCorePkg::immI;
                aSel     = rvCorePkg::aSelPc;
                bSel     = rvCorePkg::bSelFour;
                brKind   = (opcode == rvCorePkg::opJal) ? rvCorePkg::brJal : rvCorePkg::brJalr;
                wbSel    = rvCorePkg::wbPcPlus4;
                regWrRaw = 1'b1;
                bad      = (opcode == rvCorePkg::opJalr) && (funct3 != 3'b000);
            end
            rvCorePkg::opBranch: begin
                immFmt     = rvCorePkg::immB;
                bSel       = rvCorePkg::bSelRs2;
                brUnsigned = funct3[1];
                case (funct3)
                    3'b000:         brKind = rvCorePkg::brEq;
                    3'b001:         brKind = rvCorePkg::brNe;
                    3'b100, 3'b110: brKind = rvCorePkg::brLt;
                    3'b101, 3'b111: brKind = rvCorePkg::brGe;
                    default:        bad = 1'b1;
                endcase
            end
            rvCorePkg::opLoad: begin
                wbSel    = rvCorePkg::wbLoad;
                regWrRaw = 1'b1;
                memRdRaw = 1'b1;
                bad      = (funct3 == 3'b111); // no ldu
            end
            rvCorePkg::opStore: begin
                immFmt   = rvCorePkg::immS;
                memWrRaw = 1'b1;
                bad      = funct3[2];
            end
            rvCorePkg::opOpImm: begin
                aluOp    = rvCorePkg::aluOp_e'({1'b0, shiftAlt, funct3});
                regWrRaw = 1'b1;
                // funct7[0] is shamt[5] on RV64
                if (funct3 == 3'b001)
                    bad = (funct7[6:1] != 6'b000000);
                else if (funct3 == 3'b101)
                    bad = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
            end
            rvCorePkg::opOpImmW: begin
                aluOp    = rvCorePkg::aluOp_e'({1'b1, shiftAlt, funct3});
                regWrRaw = 1'b1;
                case (funct3)
                    3'b000:  bad = 1'b0;
                    3'b001:  bad = (funct7 != 7'b0000000);
                    3'b101:  bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    default: bad = 1'b1;
                endcase
            end
            rvCorePkg::opOp, rvCorePkg::opOpW: begin
                aluOp    = rvCorePkg::aluOp_e'({opcode[1], funct7[5], funct3});
                bSel     = rvCorePkg::bSelRs2;
                regWrRaw = 1'b1;
                bad      = !((funct7 == 7'b0000000) ||
                             ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));
                if (opcode == rvCorePkg::opOpW &&
                    !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101))
                    bad = 1'b1;
            end
            rvCorePkg::opSystem: begin
                if (instr == rvCorePkg::ebreakInstr)
                    brKind = rvCorePkg::brEbreak;
                else
                    bad = 1'b1; // ecall and csr ops unsupported
            end
            default: bad = 1'b1;
        endcase
    end

    assign illegal = bad || (instr[1:0] != 2'b11);
    assign regWr   = regWrRaw && !illegal;
    assign memWr   = memWrRaw && !illegal;
    assign memRd   = memRdRaw && !illegal;

endmodule

// ==== logic/rvImmGen.sv ====
module rvImmGen (
    input  logic [31:7]                   instr,
    input  rvCorePkg::immFmt_e            immFmt,
    output logic [rvCorePkg::xlen-1:0]    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            rvCorePkg::immI:
                imm = {{52{sign}}, instr[31:20]};
            rvCorePkg::immS:
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            rvCorePkg::immB:
                imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            rvCorePkg::immU:
                imm = {{32{sign}}, instr[31:12], 12'h000};
            rvCorePkg::immJ:
                imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== logic/rvNextPc.sv ====
module rvNextPc (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          advance,
    input  rvCorePkg::brKind_e            brKind,
    input  logic                          brUnsigned,
    input  logic [rvCorePkg::xlen-1:0]    rs1Data,
    input  logic [rvCorePkg::xlen-1:0]    rs2Data,
    input  logic [rvCorePkg::xlen-1:0]    imm,
    output logic [rvCorePkg::xlen-1:0]    pc,
    output logic [rvCorePkg::xlen-1:0]    pcPlus4,
    output logic                          halted
);

    logic                        isEq;
    logic                        isLt;
    logic                        taken;
    logic [rvCorePkg::xlen-1:0]  target;

    assign isEq    = (rs1Data == rs2Data);
    assign isLt    = brUnsigned ? (rs1Data < rs2Data) : ($signed(rs1Data) < $signed(rs2Data));
    assign pcPlus4 = pc + 64'd4;
    assign target  = (brKind == rvCorePkg::brJalr) ? ((rs1Data + imm) & ~64'd1) : (pc + imm);

    always_comb begin
        case (brKind)
            rvCorePkg::brJal, rvCorePkg::brJalr: taken = 1'b1;
            rvCorePkg::brEq: taken = isEq;
            rvCorePkg::brNe: taken = !isEq;
            rvCorePkg::brLt: taken = isLt;
            rvCorePkg::brGe: taken = !isLt;
            default:         taken = 1'b0; // none, ebreak
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= rvCorePkg::resetPc;
            halted <= 1'b0;
        end else if (advance) begin
            pc <= taken ? target : pcPlus4;
            if (brKind == rvCorePkg::brEbreak)
                halted <= 1'b1; // sticky until reset
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

// ==== logic/rvRegFile.sv ====
module rvRegFile (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [4:0]                    rs1Addr,
    input  logic [4:0]                    rs2Addr,
    input  logic [4:0]                    rdAddr,
    input  logic [rvCorePkg::xlen-1:0]    rdData,
    input  logic                          wrEn,
    output logic [rvCorePkg::xlen-1:0]    rs1Data,
    output logic [rvCorePkg::xlen-1:0]    rs2Data
);

    logic [rvCorePkg::xlen-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    // catches an undriven write-back path in the top level
    assert property (@(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(rdData));

endmodule

// ==== rvCore.f ====
logic/rvCorePkg.sv
logic/rvDecode.sv
logic/rvImmGen.sv
logic/rvRegFile.sv
logic/rvAlu.sv
logic/rvNextPc.sv
logic/rvCore.sv
verif/rvCoreTb.sv

// ==== verif/rvCoreTb.sv ====
module rvCoreTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk, arstN, instrValid, memWr, memRd, trap, halted;
    logic [31:0] instr;
    logic [63:0] memRdData, pc, memAddr, memWrData;
    logic [2:0]  memOp;

    logic [63:0] memArr [8];
    logic [63:0] shadowRegs [32];
    logic [63:0] shadowPc = 64'h8000_0000; // reset PC
    logic [63:0] pendPc = 64'h8000_0000;
    logic [63:0] pendVal = '0;
    logic [63:0] expAddr = '0;
    logic [63:0] expData = '0;
    logic [2:0]  expOp = '0;
    logic [4:0]  pendRd = '0;
    logic [4:0]  rd;
    logic        shadowHalted = 1'b0;
    logic        pendHalt = 1'b0;
    logic        expTrap = 1'b0;
    logic        expWr = 1'b0;
    logic        expRd = 1'b0;
    logic [31:0] lfsr = 32'd47;
    string       testName = "reset";
    int          errors = 0;
    int          issued = 0;
    int          cycles = 0;
    // reset, imm, rtype, branch, jump, illegal, halt and stall
    int          cycleLimit = 2 * (8 + 24 + 60 + 24 + 20 + 5 + 11) + 50;

    rvCore rvCore_inst (.*);

    assign memRdData = memArr[memAddr[5:3]]; // memory responder

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Test failed");
        $finish;
    end

    function automatic void logError(input string what, input logic [63:0] exp, act);
        errors++;
        $display("ERROR %s (%s): expected %h actual %h", testName, what, exp, act);
    endfunction

    assert property (@(posedge clk) disable iff (!arstN) pc == shadowPc)
        else logError("pc", shadowPc, $sampled(pc));
    assert property (@(posedge clk) disable iff (!arstN) trap == expTrap)
        else logError("trap", expTrap, $sampled(trap));
    assert property (@(posedge clk) disable iff (!arstN) halted == shadowHalted)
        else logError("halted", shadowHalted, $sampled(halted));
    assert property (@(posedge clk) disable iff (!arstN) memWr == expWr && memRd == expRd)
        else logError("strobes", {expWr, expRd}, {$sampled(memWr), $sampled(memRd)});
    assert property (@(posedge clk) disable iff (!arstN) memWr |-> memWrData == expData)
        else logError("store data", expData, $sampled(memWrData));
    assert property (@(posedge clk) disable iff (!arstN) (memWr || memRd) |-> memAddr == expAddr)
        else logError("address", expAddr, $sampled(memAddr));
    assert property (@(posedge clk) disable iff (!arstN) (memWr || memRd) |-> memOp == expOp)
        else logError("size", expOp, $sampled(memOp));

    // galois lfsr, one step per bit
    function automatic logic [63:0] rnd(input int bits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] sEnc(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] bEnc(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jEnc(input logic [20:0] imm, input logic [4:0] rdNum);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rdNum, 7'h6f};
    endfunction

    function automatic logic [63:0] aluRef(input logic [2:0] f3, input logic alt, word,
                                           input logic [63:0] a, b);
        logic [63:0] r;
        logic [5:0]  sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = {63'd0, $signed(a) < $signed(b)};
            3'b011: r = {63'd0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (word) begin
                    a = alt ? {{32{a[31]}}, a[31:0]} : {32'd0, a[31:0]};
                end
                if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return word ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic logic brTaken(input logic [2:0] f3, input logic [63:0] a, b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // retire the previous instruction into the shadow model, then drive the next one
    task automatic exec(input string name, input logic [31:0] ins, input logic valid, bad);
        logic [63:0] a, b, iImm, uImm;
        logic        adv;
        @(negedge clk);
        shadowPc = pendPc;
        if (pendRd != 5'd0) begin
            shadowRegs[pendRd] = pendVal;
        end
        shadowHalted = shadowHalted || pendHalt;
        a          = shadowRegs[ins[19:15]];
        b          = shadowRegs[ins[24:20]];
        iImm       = {{52{ins[31]}}, ins[31:20]};
        uImm       = {{32{ins[31]}}, ins[31:12], 12'h000};
        adv        = valid && !bad && !shadowHalted;
        pendPc     = adv ? shadowPc + 64'd4 : shadowPc;
        pendRd     = adv ? ins[11:7] : 5'd0;
        pendHalt   = 1'b0;
        expWr      = 1'b0;
        expRd      = 1'b0;
        expTrap    = valid && bad;
        testName   = name;
        instr      = ins;
        instrValid = valid;
        issued++;
        if (adv) begin
            case (ins[6:0])
                7'h37: pendVal = uImm; // lui
                7'h17: pendVal = shadowPc + uImm;
                7'h13: pendVal = a + iImm; // only addi is issued
                7'h33, 7'h3b: pendVal = aluRef(ins[14:12], ins[30], ins[3], a, b);
                7'h03: begin
                    expRd   = 1'b1;
                    expAddr = a + iImm;
                    expOp   = ins[14:12];
                    pendVal = memArr[expAddr[5:3]];
                end
                7'h23: begin
                    pendRd  = 5'd0;
                    expWr   = 1'b1;
                    expAddr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    expOp   = ins[14:12];
                    expData = b;
                end
                7'h63: begin
                    pendRd = 5'd0;
                    if (brTaken(ins[14:12], a, b)) begin
                        pendPc = shadowPc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    pendVal = shadowPc + 64'd4;
                    pendPc  = shadowPc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h67: begin
                    pendVal = shadowPc + 64'd4;
                    pendPc  = (a + iImm) & ~64'd1;
                end
                default: begin // ebreak
                    pendRd   = 5'd0;
                    pendHalt = 1'b1;
                end
            endcase
        end
    endtask

    initial begin
        arstN      = 1'b0;
        instr      = 32'h0000_0013;
        instrValid = 1'b0;
        foreach (shadowRegs[i]) begin
            shadowRegs[i] = '0;
        end
        foreach (memArr[i]) begin
            memArr[i] = rnd(64);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        for (int k = 0; k < 12; k++) begin
            rd = 5'(rnd(5));
            case (k % 3)
                0: exec("addi", {12'(rnd(12)), 5'(rnd(5)), 3'b000, rd, 7'h13}, 1'b1, 1'b0);
                1: exec("lui", {20'(rnd(20)), rd, 7'h37}, 1'b1, 1'b0);
                default: exec("auipc", {20'(rnd(20)), rd, 7'h17}, 1'b1, 1'b0);
            endcase
            // sb, sh, sw and sd in turn
            exec("store imm", sEnc(12'(rnd(12)), rd, 5'(rnd(5)), 3'(k % 4)), 1'b1, 1'b0);
        end

        // k = {word, alt, funct3}
        for (int k = 0; k < 32; k++) begin
            if ((k[3] && k[2:0] != 3'd0 && k[2:0] != 3'd5) ||
                (k[4] && k[2:0] != 3'd0 && k[2:0] != 3'd1 && k[2:0] != 3'd5)) begin
                continue;
            end
            exec("ld", {12'(rnd(6)), 5'd0, 3'b011, 5'd10, 7'h03}, 1'b1, 1'b0);
            exec("ld", {12'(rnd(6)), 5'd0, 3'b011, 5'd11, 7'h03}, 1'b1, 1'b0);
            exec("rtype", {1'b0, k[3], 5'd0, 5'd11, 5'd10, k[2:0], 5'd12, k[4] ? 7'h3b : 7'h33},
                 1'b1, 1'b0);
            exec("sd rtype", sEnc(12'(rnd(12)), 5'd12, 5'd0, 3'b011), 1'b1, 1'b0);
        end

        for (int k = 0; k < 16; k++) begin
            if (k[2:1] == 2'b01) begin
                continue; // funct3 2 and 3 are reserved
            end
            exec("ld", {12'(rnd(6)), 5'd0, 3'b011, 5'd13, 7'h03}, 1'b1, 1'b0);
            exec("branch", bEnc(13'(rnd(13) & ~64'd3), k[3] ? 5'd13 : 5'd10, 5'd13, k[2:0]),
                 1'b1, 1'b0);
        end

        for (int k = 0; k < 4; k++) begin
            exec("jal", jEnc(21'(rnd(21) & ~64'd3), 5'd14), 1'b1, 1'b0);
            exec("sd jal", sEnc(12'(rnd(12)), 5'd14, 5'd0, 3'b011), 1'b1, 1'b0);
            exec("auipc", {20'(rnd(20)), 5'd15, 7'h17}, 1'b1, 1'b0);
            exec("jalr", {12'(rnd(12) & ~64'd3), 5'd15, 3'b000, 5'd16, 7'h67}, 1'b1, 1'b0);
            exec("sd jalr", sEnc(12'(rnd(12)), 5'd16, 5'd0, 3'b011), 1'b1, 1'b0);
        end

        exec("bad funct7", {7'b0010000, 5'd1, 5'd2, 3'b000, 5'd3, 7'h33}, 1'b1, 1'b1);
        exec("bad load", {12'(rnd(12)), 5'd0, 3'b111, 5'd4, 7'h03}, 1'b1, 1'b1);
        exec("bad store", sEnc(12'(rnd(12)), 5'd1, 5'd0, 3'b100), 1'b1, 1'b1);
        exec("bad low bits", {12'(rnd(12)), 5'd0, 3'b000, 5'd5, 7'h12}, 1'b1, 1'b1);
        exec("sd after trap", sEnc(12'd0, 5'd3, 5'd0, 3'b011), 1'b1, 1'b0);

        exec("stall", sEnc(12'(rnd(12)), 5'd1, 5'd0, 3'b011), 1'b0, 1'b0);
        exec("stall", {12'd8, 5'd0, 3'b011, 5'd6, 7'h03}, 1'b0, 1'b0);
        exec("ebreak", 32'h0010_0073, 1'b1, 1'b0);
        for (int k = 0; k < 3; k++) begin
            exec("halted", sEnc(12'(rnd(12)), 5'd1, 5'd0, 3'b011), 1'b1, 1'b0);
            exec("halted", {12'(rnd(12)), 5'd0, 3'b000, 5'd7, 7'h13}, 1'b1, 1'b0);
        end
        exec("drain", 32'h0000_0013, 1'b0, 1'b0);
        exec("drain", 32'h0000_0013, 1'b0, 1'b0);
        @(posedge clk);
        @(negedge clk);

        $display("Finished: %0d instructions issued, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
